/* source/mtest_params.svh */
`ifndef MTEST_PARAMS_SVH
`define MTEST_PARAMS_SVH

// Stripe layout of the board
`define MTEST_NUM_S 4
`define MTEST_LANE_W 12

// Shared SRAM address bus
`define MTEST_ADDR_W 18

// Register window
`define MTEST_PADDR_W 5

`endif

/* source/mtest_pkg.sv */
`include "mtest_params.svh"

package mtest_pkg;

  // One striped word, seen flat or per chip
  typedef union packed {
    logic [`MTEST_NUM_S*`MTEST_LANE_W-1:0]      flat;
    logic [`MTEST_NUM_S-1:0][`MTEST_LANE_W-1:0] lanes;
  } stripe_word_u;

  typedef struct packed {
    logic [`MTEST_LANE_W-1:0] seed;
    logic [7:0]               num_bursts;
    logic [7:0]               num_beats;
  } mtest_cfg_t;

  typedef struct packed {
    logic        busy;
    logic        done;
    logic        pass;
    logic [15:0] err_cnt;
    logic [7:0]  run_cnt;
  } mtest_status_t;

  typedef struct packed {
    logic                     valid;
    logic                     write;
    logic [`MTEST_ADDR_W-1:0] addr;
    stripe_word_u             wdata;
  } sram_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } mtest_state_e;

endpackage

/* source/mtest_apb_regs.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_apb_regs (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`MTEST_PADDR_W-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output mtest_pkg::mtest_cfg_t     cfg,
  output logic                      start,
  input  mtest_pkg::mtest_status_t  status
);

  logic wr_en;

  // Access phase of a write, config is frozen while a run is active
  assign wr_en = psel && penable && pwrite && !status.busy;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg.seed       <= '0;
      cfg.num_bursts <= 8'd1;
      cfg.num_beats  <= 8'd16;
      start          <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_en) begin
        case (paddr)
          'h00: begin
            cfg.seed <= pwdata[27:16];
            start    <= pwdata[0];
          end
          'h04: begin
            cfg.num_bursts <= pwdata[15:8];
            cfg.num_beats  <= pwdata[7:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Zero wait states, so read data is decoded straight from paddr
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        'h04: prdata[15:0] = {cfg.num_bursts, cfg.num_beats};
        'h08: prdata[2:0] = {status.pass, status.done, status.busy};
        'h0C: prdata[15:0] = status.err_cnt;
        'h10: prdata[7:0] = status.run_cnt;
        default: prdata = '0;
      endcase
    end
  end

  // APB access phase only follows a setup phase on the same slave
  assert property (@(posedge CLK) disable iff (!rst_n) penable |-> psel)
    else $error("penable high without psel");

endmodule

/* source/mtest_fsm.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_fsm (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  mtest_pkg::mtest_cfg_t    cfg,
  input  logic                     start,
  output logic                     cnt_clear,
  output logic                     cnt_step,
  input  logic [`MTEST_ADDR_W-1:0] addr,
  input  logic                     last,
  input  mtest_pkg::stripe_word_u  wdata,
  input  logic                     rvalid,
  input  logic                     mismatch,
  output mtest_pkg::sram_cmd_t     cmd,
  output mtest_pkg::mtest_status_t status
);

  import mtest_pkg::*;

  mtest_state_e state;
  logic         beat_ph;
  logic         rd_drain;
  logic         cmp_last;
  logic [15:0]  err_cnt;
  logic [7:0]   run_cnt;
  logic         launch;
  logic         empty_run;
  logic         issuing;

  assign launch    = start && ((state == IDLE) || (state == DONE));
  assign empty_run = (cfg.num_bursts == 8'd0) || (cfg.num_beats == 8'd0);

  // Word loop is active in both passes until the read pass starts draining
  assign issuing = (state == WRITE) || ((state == READ) && !rd_drain);

  // First half of a word issues the beat, second half moves the counter
  always_comb begin
    cnt_clear = launch;
    cnt_step  = 1'b0;
    if (issuing && beat_ph) begin
      if (last) begin
        cnt_clear = (state == WRITE);
      end else begin
        cnt_step = 1'b1;
      end
    end
  end

  always_comb begin
    cmd.valid = issuing && !beat_ph;
    cmd.write = (state == WRITE);
    cmd.addr  = addr;
    cmd.wdata = wdata;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= IDLE;
      beat_ph  <= 1'b0;
      rd_drain <= 1'b0;
      cmp_last <= 1'b0;
      err_cnt  <= '0;
      run_cnt  <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (launch) begin
            err_cnt <= '0;
            beat_ph <= 1'b0;
            if (empty_run) begin
              state   <= DONE;
              run_cnt <= run_cnt + 8'd1;
            end else begin
              state <= WRITE;
            end
          end
        end
        WRITE: begin
          beat_ph <= !beat_ph;
          if (beat_ph && last) begin
            state <= READ;
          end
        end
        READ: begin
          if (mismatch && (err_cnt != 16'hFFFF)) begin
            err_cnt <= err_cnt + 16'd1;
          end
          if (cmp_last) begin
            // Mismatch of the final word is counted above in this cycle
            state    <= DONE;
            run_cnt  <= run_cnt + 8'd1;
            cmp_last <= 1'b0;
            rd_drain <= 1'b0;
          end else if (rd_drain) begin
            // Only the final read is still in flight here
            if (rvalid) begin
              cmp_last <= 1'b1;
            end
          end else begin
            beat_ph <= !beat_ph;
            if (beat_ph && last) begin
              rd_drain <= 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    status.busy    = (state == WRITE) || (state == READ);
    status.done    = (state == DONE);
    status.pass    = (state == DONE) && (err_cnt == 16'd0);
    status.err_cnt = err_cnt;
    status.run_cnt = run_cnt;
  end

  // SRAM beat takes two cycles, so commands can never be back to back
  assert property (@(posedge CLK) disable iff (!rst_n) cmd.valid |=> !cmd.valid)
    else $error("command issued while a beat is outstanding");

endmodule

/* source/mtest_beat_counter.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_beat_counter (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  mtest_pkg::mtest_cfg_t    cfg,
  input  logic                     cnt_clear,
  input  logic                     cnt_step,
  output logic [`MTEST_ADDR_W-1:0] addr,
  output logic                     last
);

  logic [7:0] burst_cnt;
  logic [7:0] beat_cnt;
  logic       beat_wrap;

  assign beat_wrap = (beat_cnt == cfg.num_beats - 8'd1);
  assign last      = beat_wrap && (burst_cnt == cfg.num_bursts - 8'd1);

  // Linear address tracks burst * num_beats + beat
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      burst_cnt <= '0;
      beat_cnt  <= '0;
      addr      <= '0;
    end else if (cnt_clear) begin
      burst_cnt <= '0;
      beat_cnt  <= '0;
      addr      <= '0;
    end else if (cnt_step) begin
      addr <= addr + 1'b1;
      if (beat_wrap) begin
        beat_cnt  <= '0;
        burst_cnt <= burst_cnt + 8'd1;
      end else begin
        beat_cnt <= beat_cnt + 8'd1;
      end
    end
  end

endmodule

/* source/mtest_pattern_gen.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_pattern_gen (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic [`MTEST_ADDR_W-1:0] addr,
  input  logic [`MTEST_LANE_W-1:0] seed,
  input  logic                     rvalid,
  input  mtest_pkg::stripe_word_u  rdata,
  output mtest_pkg::stripe_word_u  expected,
  output logic                     mismatch
);

  import mtest_pkg::*;

  logic [`MTEST_ADDR_W-1:0] addr_d1;
  logic [`MTEST_ADDR_W-1:0] addr_d2;
  stripe_word_u             rd_expected;

  // Lane s holds addr ^ seed ^ (s << 8)
  function automatic stripe_word_u pattern(input logic [`MTEST_ADDR_W-1:0] a,
                                           input logic [`MTEST_LANE_W-1:0] s_seed);
    stripe_word_u w;
    for (int s = 0; s < `MTEST_NUM_S; s++) begin
      w.lanes[s] = a[`MTEST_LANE_W-1:0] ^ s_seed ^ (`MTEST_LANE_W'(s) << 8);
    end
    return w;
  endfunction

  assign expected = pattern(addr, seed);

  // Read data lands three cycles after issue, the counter moves two cycles
  // after issue, so two stages put the read address back in line
  always_ff @(posedge CLK) begin
    addr_d1 <= addr;
    addr_d2 <= addr_d1;
  end

  assign rd_expected = pattern(addr_d2, seed);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mismatch <= 1'b0;
    end else begin
      mismatch <= rvalid && (rdata.flat != rd_expected.flat);
    end
  end

endmodule

/* source/mtest_stripe_sram_if.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_stripe_sram_if (
  input  logic                                      CLK,
  input  logic                                      rst_n,
  input  mtest_pkg::sram_cmd_t                      cmd,
  output logic                                      rvalid,
  output mtest_pkg::stripe_word_u                   rdata,
  output logic [`MTEST_ADDR_W-1:0]                  sram_addr,
  output logic [`MTEST_NUM_S-1:0]                   sram_we_n,
  output logic [`MTEST_NUM_S-1:0]                   sram_oe_n,
  inout  wire  [`MTEST_NUM_S-1:0][`MTEST_LANE_W-1:0] sram_data
);

  import mtest_pkg::*;

  logic         ph1;
  logic         ph2;
  logic         is_wr;
  logic         drive;
  logic         wr_start;
  logic         rd_start;
  stripe_word_u wdata_q;

  assign wr_start = cmd.valid && cmd.write;
  assign rd_start = cmd.valid && !cmd.write;

  // ph1 is the setup cycle of a beat, ph2 the strobe/sample cycle
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ph1       <= 1'b0;
      ph2       <= 1'b0;
      is_wr     <= 1'b0;
      drive     <= 1'b0;
      rvalid    <= 1'b0;
      sram_we_n <= '1;
      sram_oe_n <= '1;
    end else begin
      ph1 <= cmd.valid;
      ph2 <= ph1;
      if (cmd.valid) begin
        is_wr <= cmd.write;
      end
      sram_we_n <= {`MTEST_NUM_S{!(ph1 && is_wr)}};
      sram_oe_n <= {`MTEST_NUM_S{!(rd_start || (ph1 && !is_wr))}};
      drive     <= wr_start || (ph1 && is_wr);
      rvalid    <= ph2 && !is_wr;
    end
  end

  always_ff @(posedge CLK) begin
    if (cmd.valid) begin
      sram_addr <= cmd.addr;
      wdata_q   <= cmd.wdata;
    end
    if (ph2 && !is_wr) begin
      rdata.flat <= sram_data;
    end
  end

  // Each chip gets its own lane of the striped word
  for (genvar s = 0; s < `MTEST_NUM_S; s++) begin : g_lane
    assign sram_data[s] = drive ? wdata_q.lanes[s] : 'z;
  end

  assert property (@(posedge CLK) disable iff (!rst_n) &(sram_we_n | sram_oe_n))
    else $error("we_n and oe_n both low on a chip");

  // No bus fight with the chip outputs
  assert property (@(posedge CLK) disable iff (!rst_n) drive |-> &sram_oe_n)
    else $error("lanes driven while a chip output is enabled");

endmodule

/* source/mtest_top.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_top (
  input  logic                      CLK,
  input  logic                      rst_n,

  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`MTEST_PADDR_W-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,

  output logic                      sram_a_oe_n,
  output logic                      sram_a_we_n,
  output logic [`MTEST_ADDR_W-1:0]  sram_a_addr,
  inout  wire  [`MTEST_LANE_W-1:0]  sram_a_data,

  output logic                      sram_b_oe_n,
  output logic                      sram_b_we_n,
  output logic [`MTEST_ADDR_W-1:0]  sram_b_addr,
  inout  wire  [`MTEST_LANE_W-1:0]  sram_b_data,

  output logic                      sram_c_oe_n,
  output logic                      sram_c_we_n,
  output logic [`MTEST_ADDR_W-1:0]  sram_c_addr,
  inout  wire  [`MTEST_LANE_W-1:0]  sram_c_data,

  output logic                      sram_d_oe_n,
  output logic                      sram_d_we_n,
  output logic [`MTEST_ADDR_W-1:0]  sram_d_addr,
  inout  wire  [`MTEST_LANE_W-1:0]  sram_d_data
);

  import mtest_pkg::*;

  mtest_cfg_t               cfg;
  logic                     start;
  mtest_status_t            status;
  logic                     cnt_clear;
  logic                     cnt_step;
  logic [`MTEST_ADDR_W-1:0] cnt_addr;
  logic                     last;
  sram_cmd_t                cmd;
  logic                     rvalid;
  stripe_word_u             rdata;
  stripe_word_u             expected;
  logic                     mismatch;
  logic [`MTEST_ADDR_W-1:0] sram_addr;

  // Zero wait state slave
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  // All chips share one address
  assign sram_a_addr = sram_addr;
  assign sram_b_addr = sram_addr;
  assign sram_c_addr = sram_addr;
  assign sram_d_addr = sram_addr;

  mtest_apb_regs regs_inst (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .cfg    (cfg),
    .start  (start),
    .status (status)
  );

  mtest_fsm fsm_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .start    (start),
    .cnt_clear(cnt_clear),
    .cnt_step (cnt_step),
    .addr     (cnt_addr),
    .last     (last),
    .wdata    (expected),
    .rvalid   (rvalid),
    .mismatch (mismatch),
    .cmd      (cmd),
    .status   (status)
  );

  mtest_beat_counter counter_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .cnt_clear(cnt_clear),
    .cnt_step (cnt_step),
    .addr     (cnt_addr),
    .last     (last)
  );

  mtest_pattern_gen pattern_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .addr    (cnt_addr),
    .seed    (cfg.seed),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .expected(expected),
    .mismatch(mismatch)
  );

  // Lane 0 is chip a
  mtest_stripe_sram_if sram_if_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .rvalid   (rvalid),
    .rdata    (rdata),
    .sram_addr(sram_addr),
    .sram_we_n({sram_d_we_n, sram_c_we_n, sram_b_we_n, sram_a_we_n}),
    .sram_oe_n({sram_d_oe_n, sram_c_oe_n, sram_b_oe_n, sram_a_oe_n}),
    .sram_data({sram_d_data, sram_c_data, sram_b_data, sram_a_data})
  );

endmodule

/* sim/mtest_sram_model.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_sram_model (
  input  logic [`MTEST_ADDR_W-1:0] addr,
  input  logic                     we_n,
  input  logic                     oe_n,
  input  logic                     fault,
  inout  wire  [`MTEST_LANE_W-1:0] data
);

  logic [`MTEST_LANE_W-1:0] mem [0:(1 << `MTEST_ADDR_W)-1];
  logic [`MTEST_LANE_W-1:0] rd_val;

  // Bit 0 reads back as one while the fault is on
  assign rd_val = mem[addr] | {{(`MTEST_LANE_W-1){1'b0}}, fault};

  // Outputs only when read is enabled and no write is in progress
  assign data = (!oe_n && we_n) ? rd_val : 'z;

  // Cell follows the data bus while we_n is low
  always @(*) begin
    if (!we_n) begin
      mem[addr] = data;
    end
  end

endmodule

/* sim/mtest_tb.sv */
`timescale 1ns/10ps

`include "mtest_params.svh"

module mtest_tb;

  import mtest_pkg::*;

  localparam int POLL_LIMIT = 4000;
  localparam logic [`MTEST_PADDR_W-1:0] CTRL_ADDR   = 'h00;
  localparam logic [`MTEST_PADDR_W-1:0] CFG_ADDR    = 'h04;
  localparam logic [`MTEST_PADDR_W-1:0] STATUS_ADDR = 'h08;
  localparam logic [`MTEST_PADDR_W-1:0] ERR_ADDR    = 'h0C;
  localparam logic [`MTEST_PADDR_W-1:0] RUN_ADDR    = 'h10;

  typedef struct {
    string                    name;
    logic [`MTEST_LANE_W-1:0] seed;
    logic [7:0]               bursts;
    logic [7:0]               beats;
    bit                       fault;
    bit                       busy_start;
    bit                       exp_pass;
    int unsigned              exp_err;
  } test_row_t;

  logic                      CLK = 1'b0;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`MTEST_PADDR_W-1:0] paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      fault_c;

  logic [`MTEST_NUM_S-1:0]                  sram_oe_n;
  logic [`MTEST_NUM_S-1:0]                  sram_we_n;
  logic [`MTEST_NUM_S-1:0][`MTEST_ADDR_W-1:0] sram_addr;
  wire  [`MTEST_LANE_W-1:0]                 sram_a_data;
  wire  [`MTEST_LANE_W-1:0]                 sram_b_data;
  wire  [`MTEST_LANE_W-1:0]                 sram_c_data;
  wire  [`MTEST_LANE_W-1:0]                 sram_d_data;

  test_row_t rows[$];
  string     cur_test;
  int        errors;
  int        tests_run;
  int        tests_failed;
  int        runs_done;
  bit        timed_out;

  always #2 CLK = ~CLK;

  mtest_top mtest_top_inst (
    .CLK(CLK), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .sram_a_oe_n(sram_oe_n[0]), .sram_a_we_n(sram_we_n[0]),
    .sram_a_addr(sram_addr[0]), .sram_a_data(sram_a_data),
    .sram_b_oe_n(sram_oe_n[1]), .sram_b_we_n(sram_we_n[1]),
    .sram_b_addr(sram_addr[1]), .sram_b_data(sram_b_data),
    .sram_c_oe_n(sram_oe_n[2]), .sram_c_we_n(sram_we_n[2]),
    .sram_c_addr(sram_addr[2]), .sram_c_data(sram_c_data),
    .sram_d_oe_n(sram_oe_n[3]), .sram_d_we_n(sram_we_n[3]),
    .sram_d_addr(sram_addr[3]), .sram_d_data(sram_d_data)
  );

  mtest_sram_model chip_a_inst (.addr(sram_addr[0]), .we_n(sram_we_n[0]),
    .oe_n(sram_oe_n[0]), .fault(1'b0), .data(sram_a_data));
  mtest_sram_model chip_b_inst (.addr(sram_addr[1]), .we_n(sram_we_n[1]),
    .oe_n(sram_oe_n[1]), .fault(1'b0), .data(sram_b_data));
  // Chip c carries lane 2, the one with the injectable fault
  mtest_sram_model chip_c_inst (.addr(sram_addr[2]), .we_n(sram_we_n[2]),
    .oe_n(sram_oe_n[2]), .fault(fault_c), .data(sram_c_data));
  mtest_sram_model chip_d_inst (.addr(sram_addr[3]), .we_n(sram_we_n[3]),
    .oe_n(sram_oe_n[3]), .fault(1'b0), .data(sram_d_data));

  // Lane value = (A mod 4096) ^ seed ^ (lane << 8)
  function automatic logic [`MTEST_LANE_W-1:0] lane_value(input int unsigned a,
                                                          input logic [`MTEST_LANE_W-1:0] seed,
                                                          input int lane);
    logic [`MTEST_LANE_W-1:0] low;
    low = `MTEST_LANE_W'(a % 4096);
    return low ^ seed ^ `MTEST_LANE_W'(lane * 256);
  endfunction

  function automatic stripe_word_u word_value(input int unsigned a,
                                              input logic [`MTEST_LANE_W-1:0] seed);
    stripe_word_u w;
    for (int s = 0; s < `MTEST_NUM_S; s++) begin
      w.lanes[s] = lane_value(a, seed, s);
    end
    return w;
  endfunction

  // Words whose lane 2 bit 0 should be zero read back wrong under the fault
  function automatic int unsigned fault_errors(input logic [`MTEST_LANE_W-1:0] seed,
                                               input int unsigned words);
    logic [`MTEST_LANE_W-1:0] v;
    int unsigned n;
    n = 0;
    for (int unsigned a = 0; a < words; a++) begin
      v = lane_value(a, seed, 2);
      if (v[0] == 1'b0) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic stripe_word_u backdoor_word(input int unsigned a);
    stripe_word_u w;
    w.lanes[0] = chip_a_inst.mem[a];
    w.lanes[1] = chip_b_inst.mem[a];
    w.lanes[2] = chip_c_inst.mem[a];
    w.lanes[3] = chip_d_inst.mem[a];
    return w;
  endfunction

  function automatic string format_status(input mtest_status_t st);
    return $sformatf("busy=%0b done=%0b pass=%0b err_cnt=%0d run_cnt=%0d",
                     st.busy, st.done, st.pass, st.err_cnt, st.run_cnt);
  endfunction

  task automatic add_row(input string name, input bit rand_seed,
                         input logic [`MTEST_LANE_W-1:0] seed, input logic [7:0] bursts,
                         input logic [7:0] beats, input bit fault, input bit busy_start);
    test_row_t r;
    r.name       = name;
    r.seed       = rand_seed ? `MTEST_LANE_W'($urandom % 4096) : seed;
    r.bursts     = bursts;
    r.beats      = beats;
    r.fault      = fault;
    r.busy_start = busy_start;
    r.exp_err    = fault ? fault_errors(r.seed, bursts * beats) : 0;
    r.exp_pass   = (r.exp_err == 0);
    rows.push_back(r);
  endtask

  // Zero wait state slave, every access phase ends ready and without error
  task automatic check_response(input string name, input logic ready, input logic slverr);
    if (ready !== 1'b1 || slverr !== 1'b0) begin
      errors++;
      $display("MISMATCH %s: expected pready=1 pslverr=0, actual pready=%b pslverr=%b",
               name, ready, slverr);
    end
  endtask

  task automatic apb_write(input logic [`MTEST_PADDR_W-1:0] a, input logic [31:0] d);
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);
    check_response(cur_test, pready, pslverr);
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`MTEST_PADDR_W-1:0] a, output logic [31:0] d);
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge CLK);
    penable <= 1'b1;
    // Read data is stable by mid access phase
    @(negedge CLK);
    d = prdata;
    check_response(cur_test, pready, pslverr);
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_status(output mtest_status_t st);
    logic [31:0] r;
    apb_read(STATUS_ADDR, r);
    st.busy = r[0];
    st.done = r[1];
    st.pass = r[2];
    apb_read(ERR_ADDR, r);
    st.err_cnt = r[15:0];
    apb_read(RUN_ADDR, r);
    st.run_cnt = r[7:0];
  endtask

  // Polls STATUS until the selected bit is set
  task automatic wait_status_bit(input string name, input int bit_idx, output bit ok);
    logic [31:0] r;
    int polls;
    ok    = 1'b0;
    polls = 0;
    while (!ok && polls < POLL_LIMIT) begin
      apb_read(STATUS_ADDR, r);
      ok = r[bit_idx];
      polls++;
    end
    if (!ok) begin
      $display("Timeout: %s never showed status bit %0d after %0d reads", name, bit_idx,
               polls);
    end
  endtask

  task automatic check_status(input string name, input mtest_status_t exp,
                              input mtest_status_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %s, actual %s", name, format_status(exp),
               format_status(act));
    end
  endtask

  task automatic check_word(input string name, input stripe_word_u exp,
                            input stripe_word_u act);
    if (exp.flat !== act.flat) begin
      errors++;
      $display("MISMATCH %s: expected word %h, actual word %h", name, exp.flat, act.flat);
    end
  endtask

  task automatic report_test(input string name, input int errs_before, input bit finished);
    tests_run++;
    if (!finished || errors != errs_before) begin
      tests_failed++;
      $display("test %-20s failed", name);
    end else begin
      $display("test %-20s ok", name);
    end
  endtask

  initial begin
    mtest_status_t exp_st;
    mtest_status_t act_st;
    stripe_word_u  exp_w;
    stripe_word_u  act_w;
    test_row_t     row;
    int unsigned   words;
    int unsigned   probe;
    int            errs_before;
    bit            ok;

    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    fault_c      = 1'b0;
    cur_test     = "reset_values";
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    runs_done    = 0;
    timed_out    = 1'b0;

    void'($urandom(32'h40a1_cff7));
    add_row("clean_default", 1'b0, 12'h000, 8'd1, 8'd16, 1'b0, 1'b0);
    add_row("random_2x8", 1'b1, 12'h000, 8'd2, 8'd8, 1'b0, 1'b0);
    add_row("random_4x32", 1'b1, 12'h000, 8'd4, 8'd32, 1'b0, 1'b0);
    add_row("random_7x5", 1'b1, 12'h000, 8'd7, 8'd5, 1'b0, 1'b0);
    add_row("stuck_bit_chip2", 1'b1, 12'h000, 8'd3, 8'd10, 1'b1, 1'b0);
    add_row("start_while_busy", 1'b1, 12'h000, 8'd2, 8'd16, 1'b0, 1'b1);
    add_row("single_word", 1'b1, 12'h000, 8'd1, 8'd1, 1'b0, 1'b0);

    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;

    errs_before = errors;
    read_status(act_st);
    exp_st = '0;
    check_status("reset_values", exp_st, act_st);
    report_test("reset_values", errs_before, 1'b1);

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      row         = rows[i];
      cur_test    = row.name;
      errs_before = errors;
      words       = row.bursts * row.beats;
      @(posedge CLK);
      fault_c <= row.fault;
      apb_write(CFG_ADDR, {16'h0000, row.bursts, row.beats});
      apb_write(CTRL_ADDR, {4'h0, row.seed, 15'h0000, 1'b1});
      ok = 1'b1;
      if (row.busy_start) begin
        wait_status_bit(row.name, 0, ok);
        // A different seed would corrupt the read pass if it were taken
        if (ok) begin
          apb_write(CTRL_ADDR, {4'h0, ~row.seed, 15'h0000, 1'b1});
        end
      end
      if (ok) begin
        wait_status_bit(row.name, 1, ok);
      end
      if (!ok) begin
        timed_out = 1'b1;
      end else begin
        runs_done++;
        read_status(act_st);
        exp_st.busy    = 1'b0;
        exp_st.done    = 1'b1;
        exp_st.pass    = row.exp_pass;
        exp_st.err_cnt = 16'(row.exp_err);
        exp_st.run_cnt = 8'(runs_done);
        check_status(row.name, exp_st, act_st);
        probe = $urandom % words;
        exp_w = word_value(probe, row.seed);
        act_w = backdoor_word(probe);
        check_word(row.name, exp_w, act_w);
      end
      report_test(row.name, errs_before, ok);
      @(posedge CLK);
      fault_c <= 1'b0;
    end

    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
source/mtest_pkg.sv
source/mtest_apb_regs.sv
source/mtest_fsm.sv
source/mtest_beat_counter.sv
source/mtest_pattern_gen.sv
source/mtest_stripe_sram_if.sv
source/mtest_top.sv
sim/mtest_sram_model.sv
sim/mtest_tb.sv
